// File: Makefile
# Verilator build and run for the PLL reconfiguration front end

SRCS := $(shell grep -v '^+' pll_rcfg_top.f) logic/rcfg_defs.svh

.PHONY: all run clean

all: run

obj_dir/Vtb_pll_rcfg_top: pll_rcfg_top.f $(SRCS)
	verilator --binary --timing --assert -f pll_rcfg_top.f --top-module tb_pll_rcfg_top

run: obj_dir/Vtb_pll_rcfg_top
	./obj_dir/Vtb_pll_rcfg_top | tee sim.log
	grep -q '\*\*\* PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/tb_pll_rcfg_top.sv
/*
  Random testbench for the two-channel PLL reconfiguration front end.
  A transceiver slave model and a control register model sit in the testbench.
  Stimulus comes from a Galois LFSR with a fixed seed, so every run is the same.
*/
`include "rcfg_defs.svh"

module tb_pll_rcfg_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD        = 10;
  localparam int MAX_ACCESSES      = 400;
  localparam int CYCLES_PER_ACCESS = 10;

  logic                                          clk = 1'b0;
  logic                                          rst_n;
  xcvr_avmm_pkg::user_req_t                      user_req;
  xcvr_avmm_pkg::user_rsp_t                      user_rsp;
  xcvr_avmm_pkg::xcvr_req_t [`RCFG_CHANNELS-1:0] avmm_req;
  xcvr_avmm_pkg::xcvr_rsp_t [`RCFG_CHANNELS-1:0] avmm_rsp;
  xcvr_avmm_pkg::xcvr_req_t [`RCFG_CHANNELS-1:0] snap_req;
  logic [`RCFG_CHANNELS-1:0] in_pll_locked;
  logic [`RCFG_CHANNELS-1:0] in_pll_cal_busy;
  logic [`RCFG_CHANNELS-1:0] in_avmm_busy;
  logic [`RCFG_CHANNELS-1:0] in_pll_powerdown;
  logic [`RCFG_CHANNELS-1:0] out_pll_powerdown;
  logic [1:0]  stretch [`RCFG_CHANNELS];
  logic [1:0]  ctrl_model [`RCFG_CHANNELS];
  logic        strobe_seen;
  logic [1:0]  access_stretch;
  logic [31:0] lfsr_state = 32'd71755;
  int          checks = 0;
  int          errors = 0;
  int          test_start_errors = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  pll_rcfg_top u_pll_rcfg_top (
    .reconfig_clk      (clk),
    .rst_n             (rst_n),
    .user_req          (user_req),
    .user_rsp          (user_rsp),
    .avmm_req          (avmm_req),
    .avmm_rsp          (avmm_rsp),
    .in_pll_locked     (in_pll_locked),
    .in_pll_cal_busy   (in_pll_cal_busy),
    .in_avmm_busy      (in_avmm_busy),
    .in_pll_powerdown  (in_pll_powerdown),
    .out_pll_powerdown (out_pll_powerdown)
  );

  // Transceiver slave returns the address byte XOR channel times 0x11
  always_comb begin
    for (int c = 0; c < `RCFG_CHANNELS; c++) begin
      avmm_rsp[c].readdata    = avmm_req[c].address[7:0] ^ (8'(c) * 8'h11);
      avmm_rsp[c].waitrequest = (avmm_req[c].write | avmm_req[c].read) && (stretch[c] != 2'd0);
    end
  end

  // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_step();
    logic lsb;
    lsb = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return lsb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_step()};
    end
    return v;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name);
    $display("%s finished with %0d errors", name, errors - test_start_errors);
    test_start_errors = errors;
  endtask

  // One user access that starts and ends 1 ns after a rising edge
  task automatic bus_access(input logic wr, input logic [10:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output int waits);
    logic sel;
    logic done;
    sel = addr[10];
    access_stretch = 2'(rand_bits(2));
    stretch[sel] = access_stretch;
    user_req.write = wr;
    user_req.read = ~wr;
    user_req.address = addr;
    user_req.writedata = wdata;
    waits = 0;
    done = 1'b0;
    strobe_seen = 1'b0;
    while (!done) begin
      @(negedge clk);
      for (int c = 0; c < `RCFG_CHANNELS; c++) begin
        strobe_seen = strobe_seen | avmm_req[c].write | avmm_req[c].read;
      end
      snap_req = avmm_req;
      if (!user_rsp.waitrequest) begin
        rdata = user_rsp.readdata;
        done = 1'b1;
      end else begin
        waits++;
      end
      @(posedge clk);
      #1;
      if (stretch[sel] != 2'd0) begin
        stretch[sel] = stretch[sel] - 2'd1;
      end
    end
    user_req = '0;
  endtask

  initial begin
    #(MAX_ACCESSES * CYCLES_PER_ACCESS * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d accesses", MAX_ACCESSES);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    logic        sel;
    logic [10:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    int          waits;
    rst_n = 1'b0;
    user_req = '0;
    in_pll_locked = '0;
    in_pll_cal_busy = '0;
    in_avmm_busy = '0;
    in_pll_powerdown = 2'(rand_bits(2));
    for (int c = 0; c < `RCFG_CHANNELS; c++) begin
      stretch[c] = 2'd0;
      ctrl_model[c] = 2'd0;
    end
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Cleared control registers pass powerdown straight through
    @(negedge clk);
    compare_value("out_pll_powerdown", 32'(out_pll_powerdown), 32'(in_pll_powerdown));
    @(posedge clk);
    #1;
    for (int c = 0; c < `RCFG_CHANNELS; c++) begin
      bus_access(1'b0, {1'(c), 1'b1, 9'd2}, '0, rdata, waits);
      compare_value($sformatf("ctrl[%0d]", c), rdata, 32'd0);
    end
    report_test("reset_state");

    for (int i = 0; i < 40; i++) begin
      sel = 1'(rand_bits(1));
      addr = {sel, 1'b0, 9'(rand_bits(9))};
      wdata = rand_bits(32);
      bus_access(1'b1, addr, wdata, rdata, waits);
      compare_value($sformatf("avmm_req[%0d].write", sel), 32'(snap_req[sel].write), 32'd1);
      compare_value($sformatf("avmm_req[%0d].address", sel), 32'(snap_req[sel].address),
                    32'(addr[9:0]));
      compare_value($sformatf("avmm_req[%0d].writedata", sel), 32'(snap_req[sel].writedata),
                    32'(wdata[7:0]));
      compare_value($sformatf("avmm_req[%0d].write", !sel), 32'(snap_req[!sel].write), 32'd0);
      compare_value("xcvr waitrequest cycles", 32'(waits), 32'(access_stretch));
    end
    report_test("xcvr_write_routing");

    for (int i = 0; i < 40; i++) begin
      sel = 1'(rand_bits(1));
      addr = {sel, 1'b0, 9'(rand_bits(9))};
      bus_access(1'b0, addr, '0, rdata, waits);
      compare_value("user_rsp.readdata", rdata, 32'(addr[7:0] ^ (sel ? 8'h11 : 8'h00)));
      compare_value($sformatf("avmm_req[%0d].read", sel), 32'(snap_req[sel].read), 32'd1);
      compare_value($sformatf("avmm_req[%0d].read", !sel), 32'(snap_req[!sel].read), 32'd0);
      compare_value("xcvr waitrequest cycles", 32'(waits), 32'(access_stretch));
    end
    report_test("xcvr_read_return");

    for (int i = 0; i < 8; i++) begin
      sel = 1'(i);
      bus_access(1'b0, {sel, 1'b1, 9'd0}, '0, rdata, waits);
      compare_value("user_rsp.readdata", rdata, 32'h5A);
      compare_value("waitrequest cycles", 32'(waits), 32'd1);
      checks++;
      assert (!strobe_seen) else begin
        $display("Error at %0t ns: a transceiver strobe was active during a CSR read", $time);
        errors++;
      end
    end
    report_test("csr_identity");

    for (int i = 0; i < 8; i++) begin
      in_pll_locked = 2'(rand_bits(2));
      in_pll_cal_busy = 2'(rand_bits(2));
      in_avmm_busy = 2'(rand_bits(2));
      repeat (3) @(posedge clk);
      #1;
      for (int c = 0; c < `RCFG_CHANNELS; c++) begin
        bus_access(1'b0, {1'(c), 1'b1, 9'd1}, '0, rdata, waits);
        compare_value($sformatf("status[%0d]", c), rdata,
                      {29'd0, in_avmm_busy[c], in_pll_cal_busy[c], in_pll_locked[c]});
      end
    end
    report_test("status_visibility");

    for (int i = 0; i < 40; i++) begin
      sel = 1'(rand_bits(1));
      wdata = rand_bits(32);
      bus_access(1'b1, {sel, 1'b1, 9'd2}, wdata, rdata, waits);
      ctrl_model[sel] = wdata[1:0];
      in_pll_powerdown = 2'(rand_bits(2));
      @(negedge clk);
      for (int c = 0; c < `RCFG_CHANNELS; c++) begin
        compare_value($sformatf("out_pll_powerdown[%0d]", c), 32'(out_pll_powerdown[c]),
                      32'(ctrl_model[c][0] ? ctrl_model[c][1] : in_pll_powerdown[c]));
      end
      @(posedge clk);
      #1;
      bus_access(1'b0, {sel, 1'b1, 9'd2}, '0, rdata, waits);
      compare_value($sformatf("ctrl[%0d]", sel), rdata, {30'd0, ctrl_model[sel]});
    end
    report_test("powerdown_override");

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: logic/channel_csr_router.sv
/*
  Per-channel steering between the transceiver register space and the soft CSR.
  Address bit 9 selects the CSR. Write data is cut to the low byte and read data is zero-extended.
*/
`include "rcfg_defs.svh"

module channel_csr_router (
  input  logic                     reconfig_clk,
  input  logic                     rst_n,
  input  xcvr_avmm_pkg::chan_req_t chan_req,
  output xcvr_avmm_pkg::user_rsp_t chan_rsp,
  output xcvr_avmm_pkg::xcvr_req_t avmm_req,
  input  xcvr_avmm_pkg::xcvr_rsp_t avmm_rsp,
  input  pll_csr_pkg::pll_status_t status,
  input  logic                     in_pll_powerdown,
  output logic                     out_pll_powerdown
);

  logic                             csr_sel;
  logic                             csr_write;
  logic                             csr_read;
  logic [`RCFG_XCVR_DATA_WIDTH-1:0] csr_readdata;
  logic                             csr_waitrequest;
  logic [`RCFG_XCVR_DATA_WIDTH-1:0] rd_byte;

  assign csr_sel = chan_req.address[`RCFG_CSR_SEL_BIT];

  // Transceiver side sees strobes only outside the CSR window
  assign avmm_req.write     = chan_req.write & ~csr_sel;
  assign avmm_req.read      = chan_req.read & ~csr_sel;
  assign avmm_req.address   = chan_req.address;
  assign avmm_req.writedata = chan_req.writedata[`RCFG_XCVR_DATA_WIDTH-1:0];

  assign csr_write = chan_req.write & csr_sel;
  assign csr_read  = chan_req.read & csr_sel;

  pll_soft_csr u_pll_soft_csr (
    .reconfig_clk      (reconfig_clk),
    .rst_n             (rst_n),
    .csr_write         (csr_write),
    .csr_read          (csr_read),
    .csr_address       (chan_req.address[`RCFG_CSR_SEL_BIT-1:0]),
    .csr_writedata     (chan_req.writedata[`RCFG_XCVR_DATA_WIDTH-1:0]),
    .csr_readdata      (csr_readdata),
    .csr_waitrequest   (csr_waitrequest),
    .status            (status),
    .in_pll_powerdown  (in_pll_powerdown),
    .out_pll_powerdown (out_pll_powerdown)
  );

  // Response mux, then widen back to the user data width
  assign rd_byte              = csr_sel ? csr_readdata : avmm_rsp.readdata;
  assign chan_rsp.readdata    = {{(`RCFG_DATA_WIDTH-`RCFG_XCVR_DATA_WIDTH){1'b0}}, rd_byte};
  assign chan_rsp.waitrequest = csr_sel ? csr_waitrequest : avmm_rsp.waitrequest;

endmodule

// File: logic/pll_csr_pkg.sv
/*
  Soft CSR register map and field layouts.
  Offsets live in the 9-bit space below the CSR select bit.
  Unmapped offsets read zero and ignore writes.
*/
`include "rcfg_defs.svh"

package pll_csr_pkg;

  // Register offsets
  localparam logic [`RCFG_CSR_SEL_BIT-1:0] CSR_ID_OFS     = `RCFG_CSR_SEL_BIT'(0);
  localparam logic [`RCFG_CSR_SEL_BIT-1:0] CSR_STATUS_OFS = `RCFG_CSR_SEL_BIT'(1);
  localparam logic [`RCFG_CSR_SEL_BIT-1:0] CSR_CTRL_OFS   = `RCFG_CSR_SEL_BIT'(2);

  // Status register, locked lands in bit 0
  typedef struct packed {
    logic avmm_busy;
    logic cal_busy;
    logic locked;
  } pll_status_t;

  // Control register
  // pd_override in bit 0 hands powerdown to pd_value in bit 1
  typedef struct packed {
    logic pd_value;
    logic pd_override;
  } pll_ctrl_t;

endpackage

// File: logic/pll_rcfg_top.sv
/*
  Reconfiguration front end for a bank of two transceiver PLLs.
  One shared user port. The upper address bit selects the channel and bit 9 selects the soft CSR.
  Status inputs are synchronized here. Powerdown outputs are combinational.
*/
`include "rcfg_defs.svh"

module pll_rcfg_top (
  input  logic                                          reconfig_clk,
  input  logic                                          rst_n,
  input  xcvr_avmm_pkg::user_req_t                      user_req,
  output xcvr_avmm_pkg::user_rsp_t                      user_rsp,
  output xcvr_avmm_pkg::xcvr_req_t [`RCFG_CHANNELS-1:0] avmm_req,
  input  xcvr_avmm_pkg::xcvr_rsp_t [`RCFG_CHANNELS-1:0] avmm_rsp,
  input  logic [`RCFG_CHANNELS-1:0]                     in_pll_locked,
  input  logic [`RCFG_CHANNELS-1:0]                     in_pll_cal_busy,
  input  logic [`RCFG_CHANNELS-1:0]                     in_avmm_busy,
  input  logic [`RCFG_CHANNELS-1:0]                     in_pll_powerdown,
  output logic [`RCFG_CHANNELS-1:0]                     out_pll_powerdown
);

  xcvr_avmm_pkg::chan_req_t [`RCFG_CHANNELS-1:0] chan_req;
  xcvr_avmm_pkg::user_rsp_t [`RCFG_CHANNELS-1:0] chan_rsp;
  pll_csr_pkg::pll_status_t [`RCFG_CHANNELS-1:0] status;

  reconfig_if_decode u_reconfig_if_decode (
    .user_req (user_req),
    .user_rsp (user_rsp),
    .chan_req (chan_req),
    .chan_rsp (chan_rsp)
  );

  pll_status_sync u_pll_status_sync (
    .reconfig_clk    (reconfig_clk),
    .rst_n           (rst_n),
    .in_pll_locked   (in_pll_locked),
    .in_pll_cal_busy (in_pll_cal_busy),
    .in_avmm_busy    (in_avmm_busy),
    .status          (status)
  );

  // One router and soft CSR per PLL channel
  for (genvar ch = 0; ch < `RCFG_CHANNELS; ch++) begin : g_chan
    channel_csr_router u_channel_csr_router (
      .reconfig_clk      (reconfig_clk),
      .rst_n             (rst_n),
      .chan_req          (chan_req[ch]),
      .chan_rsp          (chan_rsp[ch]),
      .avmm_req          (avmm_req[ch]),
      .avmm_rsp          (avmm_rsp[ch]),
      .status            (status[ch]),
      .in_pll_powerdown  (in_pll_powerdown[ch]),
      .out_pll_powerdown (out_pll_powerdown[ch])
    );
  end

endmodule

// File: logic/pll_soft_csr.sv
/*
  Soft CSR for one PLL channel with ID, status and control registers.
  Writes complete with no wait. Reads take two cycles with registered data.
  The control register can override the PLL powerdown.
*/
`include "rcfg_defs.svh"

module pll_soft_csr (
  input  logic                             reconfig_clk,
  input  logic                             rst_n,
  input  logic                             csr_write,
  input  logic                             csr_read,
  input  logic [`RCFG_CSR_SEL_BIT-1:0]     csr_address,
  input  logic [`RCFG_XCVR_DATA_WIDTH-1:0] csr_writedata,
  output logic [`RCFG_XCVR_DATA_WIDTH-1:0] csr_readdata,
  output logic                             csr_waitrequest,
  input  pll_csr_pkg::pll_status_t         status,
  input  logic                             in_pll_powerdown,
  output logic                             out_pll_powerdown
);

  localparam int STATUS_PAD = `RCFG_XCVR_DATA_WIDTH - $bits(pll_csr_pkg::pll_status_t);
  localparam int CTRL_PAD   = `RCFG_XCVR_DATA_WIDTH - $bits(pll_csr_pkg::pll_ctrl_t);

  pll_csr_pkg::pll_ctrl_t           ctrl_q;
  logic                             rd_pending_q;
  logic [`RCFG_XCVR_DATA_WIDTH-1:0] rd_mux;
  logic [`RCFG_XCVR_DATA_WIDTH-1:0] rd_data_q;

  // Register read decode
  always_comb begin
    case (csr_address)
      pll_csr_pkg::CSR_ID_OFS:     rd_mux = `RCFG_CSR_ID;
      pll_csr_pkg::CSR_STATUS_OFS: rd_mux = {{STATUS_PAD{1'b0}}, status};
      pll_csr_pkg::CSR_CTRL_OFS:   rd_mux = {{CTRL_PAD{1'b0}}, ctrl_q};
      default:                     rd_mux = '0;
    endcase
  end

  always_ff @(posedge reconfig_clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_q       <= '0;
      rd_pending_q <= 1'b0;
    end else begin
      if (csr_write && (csr_address == pll_csr_pkg::CSR_CTRL_OFS)) begin
        ctrl_q <= pll_csr_pkg::pll_ctrl_t'(csr_writedata[$bits(pll_csr_pkg::pll_ctrl_t)-1:0]);
      end
      // Set in the first read cycle, cleared when the read completes
      rd_pending_q <= csr_read & ~rd_pending_q;
    end
  end

  // Capture read data while waitrequest is high
  always_ff @(posedge reconfig_clk) begin
    if (csr_read && !rd_pending_q) begin
      rd_data_q <= rd_mux;
    end
  end

  assign csr_readdata    = rd_data_q;
  assign csr_waitrequest = csr_read & ~rd_pending_q;

  // Override wins, otherwise the core's request passes through
  assign out_pll_powerdown = ctrl_q.pd_override ? ctrl_q.pd_value : in_pll_powerdown;

endmodule

// File: logic/pll_status_sync.sv
/*
  Two-flop synchronizers for the per-channel PLL status inputs.
  Each bit is synchronized on its own, so a multi-bit change may land over two cycles.
*/
`include "rcfg_defs.svh"

module pll_status_sync (
  input  logic                                           reconfig_clk,
  input  logic                                           rst_n,
  input  logic [`RCFG_CHANNELS-1:0]                      in_pll_locked,
  input  logic [`RCFG_CHANNELS-1:0]                      in_pll_cal_busy,
  input  logic [`RCFG_CHANNELS-1:0]                      in_avmm_busy,
  output pll_csr_pkg::pll_status_t [`RCFG_CHANNELS-1:0] status
);

  pll_csr_pkg::pll_status_t [`RCFG_CHANNELS-1:0] raw_status;
  pll_csr_pkg::pll_status_t [`RCFG_CHANNELS-1:0] meta_q;
  pll_csr_pkg::pll_status_t [`RCFG_CHANNELS-1:0] sync_q;

  // Gather the loose inputs into status records
  always_comb begin
    for (int ch = 0; ch < `RCFG_CHANNELS; ch++) begin
      raw_status[ch].locked    = in_pll_locked[ch];
      raw_status[ch].cal_busy  = in_pll_cal_busy[ch];
      raw_status[ch].avmm_busy = in_avmm_busy[ch];
    end
  end

  always_ff @(posedge reconfig_clk or negedge rst_n) begin
    if (!rst_n) begin
      meta_q <= '0;
      sync_q <= '0;
    end else begin
      meta_q <= raw_status;
      sync_q <= meta_q;
    end
  end

  assign status = sync_q;

endmodule

// File: logic/rcfg_defs.svh
/*
  Sizing constants for the two-channel PLL reconfiguration front end.
  RCFG_CHANNELS must equal 2**RCFG_SEL_BITS because the channel select is not range checked.
*/
`ifndef RCFG_DEFS_SVH
`define RCFG_DEFS_SVH

// Channel count and the width of the select field above the channel address
`define RCFG_CHANNELS        2
`define RCFG_SEL_BITS        1

// Per-channel address and the two data widths
`define RCFG_ADDR_BITS       10
`define RCFG_DATA_WIDTH      32
`define RCFG_XCVR_DATA_WIDTH 8

// Address bit that steers an access into the soft CSR
`define RCFG_CSR_SEL_BIT     9

// Value returned by the CSR identifier register
`define RCFG_CSR_ID          8'h5A

`endif

// File: logic/reconfig_if_decode.sv
/*
  Splits the shared user port into one request per channel.
  Only the addressed channel sees strobes. The response mux is purely combinational.
*/
`include "rcfg_defs.svh"

module reconfig_if_decode (
  input  xcvr_avmm_pkg::user_req_t                      user_req,
  output xcvr_avmm_pkg::user_rsp_t                      user_rsp,
  output xcvr_avmm_pkg::chan_req_t [`RCFG_CHANNELS-1:0] chan_req,
  input  xcvr_avmm_pkg::user_rsp_t [`RCFG_CHANNELS-1:0] chan_rsp
);

  logic [`RCFG_SEL_BITS-1:0] chan_sel;

  // Upper address bits pick the channel
  assign chan_sel = user_req.address[`RCFG_ADDR_BITS +: `RCFG_SEL_BITS];

  always_comb begin
    for (int ch = 0; ch < `RCFG_CHANNELS; ch++) begin
      // Strobes go only to the selected channel
      chan_req[ch].write     = user_req.write & (chan_sel == `RCFG_SEL_BITS'(ch));
      chan_req[ch].read      = user_req.read & (chan_sel == `RCFG_SEL_BITS'(ch));
      // Address and data are broadcast
      chan_req[ch].address   = user_req.address[`RCFG_ADDR_BITS-1:0];
      chan_req[ch].writedata = user_req.writedata;
    end
  end

  // Read data and waitrequest come back from the addressed channel
  assign user_rsp = chan_rsp[chan_sel];

endmodule

// File: logic/xcvr_avmm_pkg.sv
/*
  Request and response types for the user reconfiguration port and the transceiver port.
  Both sides follow the plain waitrequest protocol with no readdatavalid.
*/
`include "rcfg_defs.svh"

package xcvr_avmm_pkg;

  // Shared user port, channel select sits above the per-channel address
  typedef struct packed {
    logic                                      write;
    logic                                      read;
    logic [`RCFG_SEL_BITS+`RCFG_ADDR_BITS-1:0] address;
    logic [`RCFG_DATA_WIDTH-1:0]               writedata;
  } user_req_t;

  typedef struct packed {
    logic [`RCFG_DATA_WIDTH-1:0] readdata;
    logic                        waitrequest;
  } user_rsp_t;

  // One channel after the select has been stripped
  typedef struct packed {
    logic                        write;
    logic                        read;
    logic [`RCFG_ADDR_BITS-1:0]  address;
    logic [`RCFG_DATA_WIDTH-1:0] writedata;
  } chan_req_t;

  // Byte-wide transceiver register port
  typedef struct packed {
    logic                             write;
    logic                             read;
    logic [`RCFG_ADDR_BITS-1:0]       address;
    logic [`RCFG_XCVR_DATA_WIDTH-1:0] writedata;
  } xcvr_req_t;

  typedef struct packed {
    logic [`RCFG_XCVR_DATA_WIDTH-1:0] readdata;
    logic                             waitrequest;
  } xcvr_rsp_t;

endpackage

// File: pll_rcfg_top.f
+incdir+logic
logic/xcvr_avmm_pkg.sv
logic/pll_csr_pkg.sv
logic/reconfig_if_decode.sv
logic/pll_status_sync.sv
logic/pll_soft_csr.sv
logic/channel_csr_router.sv
logic/pll_rcfg_top.sv
dv/tb_pll_rcfg_top.sv
